// ==== logic/rv32i_consts.svh ====
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Width of one data word and of a register index
`define XLEN 32
`define REG_BITS 5
// Architectural registers, x0 included
`define NUM_REGS 32

// Instruction queue entries, which is also the credit count a source starts with
`define QUEUE_DEPTH 4

// Major opcodes of the register-register and register-immediate groups
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011

`endif

// ==== logic/rv32i_pkg.sv ====
`include "rv32i_consts.svh"

package rv32i_pkg;

  // One architectural data word
  typedef logic [`XLEN-1:0] xlen_t;

  // Index into the register file
  typedef logic [`REG_BITS-1:0] reg_addr_t;

  // Operations done by the single-cycle ALU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Operations done by the iterative shifter
  typedef enum logic [1:0] {
    SHIFT_SLL,
    SHIFT_SRL,
    SHIFT_SRA
  } shift_op_e;

  // Execution unit a micro-operation is sent to
  typedef enum logic {
    UNIT_ALU,
    UNIT_SHIFT
  } exec_unit_e;

endpackage

// ==== logic/rv32i_decode.sv ====
`include "rv32i_consts.svh"

module rv32i_decode (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   instr_valid_i,
  input  rv32i_pkg::xlen_t       instr_i,
  output logic                   credit_o,
  output logic                   illegal_o,
  output logic                   dec_valid_o,
  input  logic                   dec_ready_i,
  output rv32i_pkg::exec_unit_e  dec_unit_o,
  output rv32i_pkg::alu_op_e     dec_alu_op_o,
  output rv32i_pkg::shift_op_e   dec_shift_op_o,
  output rv32i_pkg::reg_addr_t   dec_rd_o,
  output rv32i_pkg::reg_addr_t   dec_rs1_o,
  output rv32i_pkg::reg_addr_t   dec_rs2_o,
  output logic                   dec_use_imm_o,
  output rv32i_pkg::xlen_t       dec_imm_o
);

  localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);

  rv32i_pkg::xlen_t     queue_mem [`QUEUE_DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [PTR_BITS:0]    count;
  rv32i_pkg::xlen_t     head;
  logic                 head_valid;
  logic                 head_illegal;
  logic                 pop;
  logic                 is_op;
  logic                 is_imm;
  logic                 f7_zero;
  logic                 f7_alt;

  //////////////////////////////////////////////////////////////////////
  // Instruction queue
  //////////////////////////////////////////////////////////////////////

  // The source only sends while it holds credits, so a push never gets refused
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      queue_mem[wr_ptr] <= instr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({instr_valid_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head       = queue_mem[rd_ptr];
  assign head_valid = (count != '0);

  // Illegal words leave at once, legal ones wait for opfetch
  assign pop         = head_valid & (head_illegal | dec_ready_i);
  assign credit_o    = pop;
  assign illegal_o   = head_valid & head_illegal;
  assign dec_valid_o = head_valid & ~head_illegal;

  //////////////////////////////////////////////////////////////////////
  // Decoder for the queue head
  //////////////////////////////////////////////////////////////////////

  assign is_op   = (head[6:0] == `OPC_OP);
  assign is_imm  = (head[6:0] == `OPC_OP_IMM);
  assign f7_zero = (head[31:25] == 7'b0000000);
  assign f7_alt  = (head[31:25] == 7'b0100000);

  assign dec_rd_o      = head[11:7];
  assign dec_rs1_o     = head[19:15];
  // Immediate forms read no rs2, and x0 is never busy, so no false hazard
  assign dec_rs2_o     = is_imm ? '0 : head[24:20];
  assign dec_use_imm_o = is_imm;

  always_comb begin
    head_illegal   = 1'b0;
    dec_unit_o     = rv32i_pkg::UNIT_ALU;
    dec_alu_op_o   = rv32i_pkg::ALU_ADD;
    dec_shift_op_o = rv32i_pkg::SHIFT_SLL;
    dec_imm_o      = {{(`XLEN-12){head[31]}}, head[31:20]};
    case (head[14:12])
      3'b000: begin
        // funct7 only selects SUB in the register form; ADDI has an immediate there
        if (is_op & f7_alt) begin
          dec_alu_op_o = rv32i_pkg::ALU_SUB;
        end
        head_illegal = is_op & ~f7_zero & ~f7_alt;
      end
      3'b001: begin
        dec_unit_o   = rv32i_pkg::UNIT_SHIFT;
        head_illegal = ~f7_zero;
      end
      3'b010: begin
        dec_alu_op_o = rv32i_pkg::ALU_SLT;
        head_illegal = is_op & ~f7_zero;
      end
      3'b011: begin
        dec_alu_op_o = rv32i_pkg::ALU_SLTU;
        head_illegal = is_op & ~f7_zero;
      end
      3'b100: begin
        dec_alu_op_o = rv32i_pkg::ALU_XOR;
        head_illegal = is_op & ~f7_zero;
      end
      3'b101: begin
        dec_unit_o     = rv32i_pkg::UNIT_SHIFT;
        dec_shift_op_o = f7_alt ? rv32i_pkg::SHIFT_SRA : rv32i_pkg::SHIFT_SRL;
        head_illegal   = ~f7_zero & ~f7_alt;
      end
      3'b110: begin
        dec_alu_op_o = rv32i_pkg::ALU_OR;
        head_illegal = is_op & ~f7_zero;
      end
      default: begin
        dec_alu_op_o = rv32i_pkg::ALU_AND;
        head_illegal = is_op & ~f7_zero;
      end
    endcase
    // Shift immediates carry the amount in the shamt field only
    if (dec_unit_o == rv32i_pkg::UNIT_SHIFT) begin
      dec_imm_o = {{(`XLEN-5){1'b0}}, head[24:20]};
    end
    if (!(is_op | is_imm)) begin
      head_illegal = 1'b1;
    end
  end

  // Credit accounting at the source must keep the queue from overflowing
  a_queue_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_valid_i |-> (count != `QUEUE_DEPTH));

endmodule

// ==== logic/rv32i_registers.sv ====
`include "rv32i_consts.svh"

module rv32i_registers (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  write_i,
  input  rv32i_pkg::reg_addr_t  rd_i,
  input  rv32i_pkg::xlen_t      data_i,
  input  rv32i_pkg::reg_addr_t  rs1_addr_i,
  input  rv32i_pkg::reg_addr_t  rs2_addr_i,
  output rv32i_pkg::xlen_t      rs1_o,
  output rv32i_pkg::xlen_t      rs2_o
);

  // Architectural state, all registers start from zero
  rv32i_pkg::xlen_t regs [`NUM_REGS];

  // x0 is never written, so it keeps the zero from reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_i && (rd_i != '0)) begin
      regs[rd_i] <= data_i;
    end
  end

  // No write bypass here
  // The scoreboard holds a reader until the cycle after its producer writes
  assign rs1_o = regs[rs1_addr_i];
  assign rs2_o = regs[rs2_addr_i];

endmodule

// ==== logic/rv32i_opfetch.sv ====
`include "rv32i_consts.svh"

module rv32i_opfetch (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   dec_valid_i,
  output logic                   dec_ready_o,
  input  rv32i_pkg::exec_unit_e  dec_unit_i,
  input  rv32i_pkg::alu_op_e     dec_alu_op_i,
  input  rv32i_pkg::shift_op_e   dec_shift_op_i,
  input  rv32i_pkg::reg_addr_t   dec_rd_i,
  input  rv32i_pkg::reg_addr_t   dec_rs1_i,
  input  rv32i_pkg::reg_addr_t   dec_rs2_i,
  input  logic                   dec_use_imm_i,
  input  rv32i_pkg::xlen_t       dec_imm_i,
  output rv32i_pkg::reg_addr_t   rs1_addr_o,
  output rv32i_pkg::reg_addr_t   rs2_addr_o,
  input  rv32i_pkg::xlen_t       rs1_i,
  input  rv32i_pkg::xlen_t       rs2_i,
  input  logic                   wb_write_i,
  input  rv32i_pkg::reg_addr_t   wb_rd_i,
  input  logic                   shift_busy_i,
  output logic                   alu_issue_o,
  output logic                   shift_issue_o,
  output rv32i_pkg::alu_op_e     alu_op_o,
  output rv32i_pkg::shift_op_e   shift_op_o,
  output rv32i_pkg::reg_addr_t   issue_rd_o,
  output rv32i_pkg::xlen_t       operand1_o,
  output rv32i_pkg::xlen_t       operand2_o
);

  logic                   valid_q;
  rv32i_pkg::exec_unit_e  unit_q;
  logic                   use_imm_q;
  rv32i_pkg::xlen_t       imm_q;
  logic [`NUM_REGS-1:0]   busy;
  logic                   hazard;
  logic                   unit_free;
  logic                   issue;

  //////////////////////////////////////////////////////////////////////
  // Micro-operation register
  //////////////////////////////////////////////////////////////////////

  // A new entry is taken when the slot is empty or is issuing this cycle
  assign dec_ready_o = ~valid_q | issue;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (dec_ready_o) begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_ready_o && dec_valid_i) begin
      unit_q     <= dec_unit_i;
      alu_op_o   <= dec_alu_op_i;
      shift_op_o <= dec_shift_op_i;
      issue_rd_o <= dec_rd_i;
      rs1_addr_o <= dec_rs1_i;
      rs2_addr_o <= dec_rs2_i;
      use_imm_q  <= dec_use_imm_i;
      imm_q      <= dec_imm_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard and issue
  //////////////////////////////////////////////////////////////////////

  // Checking rd too keeps writes to one register in program order
  assign hazard    = busy[rs1_addr_o] | busy[rs2_addr_o] | busy[issue_rd_o];
  assign unit_free = (unit_q == rv32i_pkg::UNIT_ALU) | ~shift_busy_i;
  assign issue     = valid_q & ~hazard & unit_free;

  assign alu_issue_o   = issue & (unit_q == rv32i_pkg::UNIT_ALU);
  assign shift_issue_o = issue & (unit_q == rv32i_pkg::UNIT_SHIFT);
  assign operand1_o    = rs1_i;
  assign operand2_o    = use_imm_q ? imm_q : rs2_i;

  // The bit cleared by writeback is always already set, so it never
  // collides with the bit set by this cycle's issue
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy <= '0;
    end else begin
      if (wb_write_i) begin
        busy[wb_rd_i] <= 1'b0;
      end
      if (issue && (issue_rd_o != '0)) begin
        busy[issue_rd_o] <= 1'b1;
      end
    end
  end

  // Operands must come from the register file after their producer retired
  // The register file has no bypass, so a source written in the issue cycle reads stale
  a_no_source_write: assert property (@(posedge clk_i) disable iff (reset_i)
    (alu_issue_o | shift_issue_o) && wb_write_i && (wb_rd_i != '0) |->
      (wb_rd_i != rs1_addr_o) && (wb_rd_i != rs2_addr_o));

  // Writeback only ever retires a register that an earlier issue marked busy
  a_clear_busy_only: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_write_i |-> busy[wb_rd_i]);

endmodule

// ==== logic/rv32i_alu.sv ====
module rv32i_alu (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  issue_i,
  input  rv32i_pkg::alu_op_e    op_i,
  input  rv32i_pkg::reg_addr_t  rd_i,
  input  rv32i_pkg::xlen_t      operand1_i,
  input  rv32i_pkg::xlen_t      operand2_i,
  output logic                  done_o,
  output rv32i_pkg::reg_addr_t  done_rd_o,
  output rv32i_pkg::xlen_t      result_o
);

  rv32i_pkg::xlen_t result_next;

  // Compares yield 0 or 1 in the low bit
  always_comb begin
    case (op_i)
      rv32i_pkg::ALU_ADD:  result_next = operand1_i + operand2_i;
      rv32i_pkg::ALU_SUB:  result_next = operand1_i - operand2_i;
      rv32i_pkg::ALU_AND:  result_next = operand1_i & operand2_i;
      rv32i_pkg::ALU_OR:   result_next = operand1_i | operand2_i;
      rv32i_pkg::ALU_XOR:  result_next = operand1_i ^ operand2_i;
      rv32i_pkg::ALU_SLT: begin
        result_next = rv32i_pkg::xlen_t'($signed(operand1_i) < $signed(operand2_i));
      end
      rv32i_pkg::ALU_SLTU: begin
        result_next = rv32i_pkg::xlen_t'(operand1_i < operand2_i);
      end
      default:             result_next = '0;
    endcase
  end

  // No internal stall, so the result is always ready one cycle after issue
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      done_rd_o <= rd_i;
      result_o  <= result_next;
    end
  end

endmodule

// ==== logic/rv32i_shifter.sv ====
module rv32i_shifter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  issue_i,
  input  rv32i_pkg::shift_op_e  op_i,
  input  rv32i_pkg::reg_addr_t  rd_i,
  input  rv32i_pkg::xlen_t      operand1_i,
  input  rv32i_pkg::xlen_t      operand2_i,
  output logic                  busy_o,
  output logic                  done_o,
  output rv32i_pkg::reg_addr_t  done_rd_o,
  output rv32i_pkg::xlen_t      result_o,
  input  logic                  accept_i
);

  rv32i_pkg::shift_op_e  op_q;
  logic [4:0]            amount;
  logic [4:0]            remaining;

  // One position in the direction of the operation, SRA copies the sign bit
  function automatic rv32i_pkg::xlen_t shift_one(input rv32i_pkg::xlen_t value,
                                                 input rv32i_pkg::shift_op_e op);
    case (op)
      rv32i_pkg::SHIFT_SLL: shift_one = value << 1;
      rv32i_pkg::SHIFT_SRL: shift_one = value >> 1;
      rv32i_pkg::SHIFT_SRA: shift_one = rv32i_pkg::xlen_t'($signed(value) >>> 1);
      default:              shift_one = value;
    endcase
  endfunction

  assign amount = operand2_i[4:0];

  // The first step is taken while loading, so an amount of k takes k cycles
  // and an amount of zero still takes one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end else if (issue_i) begin
      busy_o <= 1'b1;
      done_o <= (amount <= 5'd1);
    end else if (done_o) begin
      // Result stays on the outputs until writeback takes it
      if (accept_i) begin
        busy_o <= 1'b0;
        done_o <= 1'b0;
      end
    end else if (busy_o) begin
      done_o <= (remaining == 5'd1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      op_q      <= op_i;
      done_rd_o <= rd_i;
      remaining <= amount - 5'd1;
      result_o  <= (amount == 5'd0) ? operand1_i : shift_one(operand1_i, op_i);
    end else if (busy_o && !done_o) begin
      remaining <= remaining - 5'd1;
      result_o  <= shift_one(result_o, op_q);
    end
  end

  // Opfetch has to honour busy_o, or a running shift gets overwritten
  a_no_issue_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_i |-> !busy_o);

endmodule

// ==== logic/rv32i_writeback.sv ====
module rv32i_writeback (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  alu_done_i,
  input  rv32i_pkg::reg_addr_t  alu_rd_i,
  input  rv32i_pkg::xlen_t      alu_result_i,
  input  logic                  shift_done_i,
  input  rv32i_pkg::reg_addr_t  shift_rd_i,
  input  rv32i_pkg::xlen_t      shift_result_i,
  output logic                  shift_accept_o,
  output logic                  wb_write_o,
  output rv32i_pkg::reg_addr_t  wb_rd_o,
  output rv32i_pkg::xlen_t      wb_data_o
);

  // ALU results cannot be held, so the shifter only gets the port when the ALU is idle
  assign shift_accept_o = shift_done_i & ~alu_done_i;

  // Writes to x0 are dropped here and never reach the retire port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_write_o <= 1'b0;
    end else begin
      wb_write_o <= (alu_done_i & (alu_rd_i != '0)) |
                    (shift_accept_o & (shift_rd_i != '0));
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_done_i) begin
      wb_rd_o   <= alu_rd_i;
      wb_data_o <= alu_result_i;
    end else if (shift_accept_o) begin
      wb_rd_o   <= shift_rd_i;
      wb_data_o <= shift_result_i;
    end
  end

endmodule

// ==== logic/rv32i_pipe.sv ====
module rv32i_pipe (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  rv32i_pkg::xlen_t      instr_i,
  output logic                  credit_o,
  output logic                  illegal_o,
  output logic                  retire_valid_o,
  output rv32i_pkg::reg_addr_t  retire_rd_o,
  output rv32i_pkg::xlen_t      retire_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Stage to stage wiring
  //////////////////////////////////////////////////////////////////////

  // Decode to opfetch
  logic                   dec_valid;
  logic                   dec_ready;
  rv32i_pkg::exec_unit_e  dec_unit;
  rv32i_pkg::alu_op_e     dec_alu_op;
  rv32i_pkg::shift_op_e   dec_shift_op;
  rv32i_pkg::reg_addr_t   dec_rd;
  rv32i_pkg::reg_addr_t   dec_rs1;
  rv32i_pkg::reg_addr_t   dec_rs2;
  logic                   dec_use_imm;
  rv32i_pkg::xlen_t       dec_imm;

  // Register file read ports
  rv32i_pkg::reg_addr_t   rs1_addr;
  rv32i_pkg::reg_addr_t   rs2_addr;
  rv32i_pkg::xlen_t       rs1_data;
  rv32i_pkg::xlen_t       rs2_data;

  // Issue to the units
  logic                   alu_issue;
  logic                   shift_issue;
  rv32i_pkg::alu_op_e     issue_alu_op;
  rv32i_pkg::shift_op_e   issue_shift_op;
  rv32i_pkg::reg_addr_t   issue_rd;
  rv32i_pkg::xlen_t       operand1;
  rv32i_pkg::xlen_t       operand2;
  logic                   shift_busy;

  // Unit results and the combined write
  logic                   alu_done;
  rv32i_pkg::reg_addr_t   alu_done_rd;
  rv32i_pkg::xlen_t       alu_result;
  logic                   shift_done;
  rv32i_pkg::reg_addr_t   shift_done_rd;
  rv32i_pkg::xlen_t       shift_result;
  logic                   shift_accept;
  logic                   wb_write;
  rv32i_pkg::reg_addr_t   wb_rd;
  rv32i_pkg::xlen_t       wb_data;

  rv32i_decode u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .credit_o       (credit_o),
    .illegal_o      (illegal_o),
    .dec_valid_o    (dec_valid),
    .dec_ready_i    (dec_ready),
    .dec_unit_o     (dec_unit),
    .dec_alu_op_o   (dec_alu_op),
    .dec_shift_op_o (dec_shift_op),
    .dec_rd_o       (dec_rd),
    .dec_rs1_o      (dec_rs1),
    .dec_rs2_o      (dec_rs2),
    .dec_use_imm_o  (dec_use_imm),
    .dec_imm_o      (dec_imm)
  );

  rv32i_registers u_registers (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .write_i    (wb_write),
    .rd_i       (wb_rd),
    .data_i     (wb_data),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_o      (rs1_data),
    .rs2_o      (rs2_data)
  );

  rv32i_opfetch u_opfetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dec_valid_i    (dec_valid),
    .dec_ready_o    (dec_ready),
    .dec_unit_i     (dec_unit),
    .dec_alu_op_i   (dec_alu_op),
    .dec_shift_op_i (dec_shift_op),
    .dec_rd_i       (dec_rd),
    .dec_rs1_i      (dec_rs1),
    .dec_rs2_i      (dec_rs2),
    .dec_use_imm_i  (dec_use_imm),
    .dec_imm_i      (dec_imm),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_i          (rs1_data),
    .rs2_i          (rs2_data),
    .wb_write_i     (wb_write),
    .wb_rd_i        (wb_rd),
    .shift_busy_i   (shift_busy),
    .alu_issue_o    (alu_issue),
    .shift_issue_o  (shift_issue),
    .alu_op_o       (issue_alu_op),
    .shift_op_o     (issue_shift_op),
    .issue_rd_o     (issue_rd),
    .operand1_o     (operand1),
    .operand2_o     (operand2)
  );

  rv32i_alu u_alu (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue_i    (alu_issue),
    .op_i       (issue_alu_op),
    .rd_i       (issue_rd),
    .operand1_i (operand1),
    .operand2_i (operand2),
    .done_o     (alu_done),
    .done_rd_o  (alu_done_rd),
    .result_o   (alu_result)
  );

  rv32i_shifter u_shifter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue_i    (shift_issue),
    .op_i       (issue_shift_op),
    .rd_i       (issue_rd),
    .operand1_i (operand1),
    .operand2_i (operand2),
    .busy_o     (shift_busy),
    .done_o     (shift_done),
    .done_rd_o  (shift_done_rd),
    .result_o   (shift_result),
    .accept_i   (shift_accept)
  );

  rv32i_writeback u_writeback (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .alu_done_i     (alu_done),
    .alu_rd_i       (alu_done_rd),
    .alu_result_i   (alu_result),
    .shift_done_i   (shift_done),
    .shift_rd_i     (shift_done_rd),
    .shift_result_i (shift_result),
    .shift_accept_o (shift_accept),
    .wb_write_o     (wb_write),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data)
  );

  // Every register file write is also a retire
  assign retire_valid_o = wb_write;
  assign retire_rd_o    = wb_rd;
  assign retire_data_o  = wb_data;

endmodule

// ==== tb/rv32i_pipe_tb.sv ====
`include "rv32i_consts.svh"

module rv32i_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          MAX_TESTS    = 64;
  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 8;
  localparam int          DRAIN_CYCLES = 40;
  localparam logic [31:0] KIND_ILLEGAL = 32'h1;
  localparam logic [31:0] KIND_END     = 32'hf;
  localparam logic [31:0] LFSR_SEED    = 32'h70d9_85cd;
  // Taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic                  clk_i;
  logic                  reset_i;
  logic                  instr_valid_i;
  rv32i_pkg::xlen_t      instr_i;
  logic                  credit_o;
  logic                  illegal_o;
  logic                  retire_valid_o;
  rv32i_pkg::reg_addr_t  retire_rd_o;
  rv32i_pkg::xlen_t      retire_data_o;

  // Four words per test: instruction, kind, rd, expected value
  logic [31:0]           test_mem [MAX_TESTS*4];
  int                    num_tests;
  bit                    tests_loaded = 1'b0;
  // Pending retires in file order, searched per rd
  rv32i_pkg::reg_addr_t  exp_rd_q [$];
  rv32i_pkg::xlen_t      exp_data_q [$];
  int                    expected_illegal;
  int                    expected_retires;
  int                    credits;
  int                    sent_count;
  int                    credit_count;
  int                    illegal_count;
  int                    retire_count;
  int                    error_count;
  logic [31:0]           lfsr;

  rv32i_pipe dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .credit_o       (credit_o),
    .illegal_o      (illegal_o),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois form, the bit shifted out decides whether the taps are applied
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next_state;
    next_state = state >> 1;
    if (state[0]) begin
      next_state = next_state ^ LFSR_TAPS;
    end
    return next_state;
  endfunction

  task automatic take_bit(output logic value);
    value = lfsr[0];
    lfsr  = lfsr_step(lfsr);
  endtask

  // Reads the test file and queues the expected retires in file order
  task automatic load_tests();
    logic [31:0] kind;
    $readmemh("tb/rv32i_pipe_tests.txt", test_mem);
    num_tests        = 0;
    expected_illegal = 0;
    expected_retires = 0;
    while (num_tests < MAX_TESTS && test_mem[num_tests*4+1] != KIND_END) begin
      kind = test_mem[num_tests*4+1];
      if (kind == KIND_ILLEGAL) begin
        expected_illegal++;
      end else if (test_mem[num_tests*4+2] != 32'h0) begin
        // Writes to x0 are legal but never show up on the retire port
        expected_retires++;
        exp_rd_q.push_back(test_mem[num_tests*4+2][`REG_BITS-1:0]);
        exp_data_q.push_back(test_mem[num_tests*4+3]);
      end
      num_tests++;
    end
    if (num_tests == 0) begin
      error_count++;
      $display("%0t: the test file holds no tests", $time);
    end
    tests_loaded = 1'b1;
  endtask

  // The oldest pending entry for this rd must match, other registers may retire earlier
  task automatic check_retire(input rv32i_pkg::reg_addr_t rd, input rv32i_pkg::xlen_t data);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_rd_q.size(); i++) begin
      if (exp_rd_q[i] == rd) begin
        idx = i;
        break;
      end
    end
    if (idx < 0) begin
      error_count++;
      $display("%0t: retire to x%0d that no remaining test expects", $time, rd);
    end else begin
      if (data !== exp_data_q[idx]) begin
        error_count++;
        $display("[FAIL] %0t retire_data_o (x%0d) expected %h actual %h",
                 $time, rd, exp_data_q[idx], data);
      end
      exp_rd_q.delete(idx);
      exp_data_q.delete(idx);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      error_count++;
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  // Called once per falling edge, where every DUT output is settled
  task automatic sample_outputs();
    if (credit_o) begin
      credit_count++;
      credits++;
      if (credits > `QUEUE_DEPTH) begin
        error_count++;
        $display("%0t: a credit came back that was never spent", $time);
      end
    end
    if (illegal_o) begin
      illegal_count++;
    end
    if (retire_valid_o) begin
      retire_count++;
      check_retire(retire_rd_o, retire_data_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Credit tracking source and checker
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic gap_a;
    logic gap_b;
    int   next_test;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    reset_i       = 1'b1;
    lfsr          = LFSR_SEED;
    credits       = `QUEUE_DEPTH;
    sent_count    = 0;
    credit_count  = 0;
    illegal_count = 0;
    retire_count  = 0;
    error_count   = 0;
    next_test     = 0;
    load_tests();
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    // Runs until every word is sent, every credit is back and every retire is seen
    while (next_test < num_tests || credits != `QUEUE_DEPTH || exp_rd_q.size() != 0) begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      // The send decision uses credits held before this cycle's returns,
      // so a full queue is never written in the cycle it pops
      if (next_test < num_tests && credits > 0) begin
        take_bit(gap_a);
        take_bit(gap_b);
        // One idle cycle in four on average
        if (!(gap_a && gap_b)) begin
          instr_valid_i = 1'b1;
          instr_i       = test_mem[next_test*4];
          credits--;
          sent_count++;
          next_test++;
        end
      end
      sample_outputs();
    end
    // Extra cycles catch late or duplicate retires, x0 writes included
    repeat (DRAIN_CYCLES) begin
      @(negedge clk_i);
      sample_outputs();
    end
    check_count("credit_o pulses", sent_count, credit_count);
    check_count("illegal_o pulses", expected_illegal, illegal_count);
    check_count("retire_valid_o pulses", expected_retires, retire_count);
    check_count("credits held by source", `QUEUE_DEPTH, credits);
    $display("tests %0d sent %0d credits %0d illegal %0d retires %0d errors %0d",
             num_tests, sent_count, credit_count, illegal_count, retire_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  // Forty cycles per test is far above the longest shift chain
  initial begin
    time limit;
    wait (tests_loaded);
    limit = num_tests * 40 * CLK_PERIOD;
    #(limit);
    $display("%0t: watchdog expired with %0d of %0d tests sent", $time, sent_count, num_tests);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== tb/rv32i_pipe_tests.txt ====
// Columns: instruction word, kind (0 legal, 1 illegal, f end of list), rd, expected value
// Expected values follow RV32I with every register starting at zero
00500093 0 01 00000005  // addi x1, x0, 5
ffd00113 0 02 fffffffd  // addi x2, x0, -3
002081b3 0 03 00000002  // add x3, x1, x2
40208233 0 04 00000008  // sub x4, x1, x2
401002b3 0 05 fffffffb  // sub x5, x0, x1
00112333 0 06 00000001  // slt x6, x2, x1
001133b3 0 07 00000000  // sltu x7, x2, x1
fff12413 0 08 00000001  // slti x8, x2, -1
fff0b493 0 09 00000001  // sltiu x9, x1, -1
fff0c513 0 0a fffffffa  // xori x10, x1, -1
7f00e593 0 0b 000007f5  // ori x11, x1, 0x7f0
0f017613 0 0c 000000f0  // andi x12, x2, 0xf0
0020f6b3 0 0d 00000005  // and x13, x1, x2
0020c7b3 0 0f fffffff8  // xor x15, x1, x2
01f09813 0 10 80000000  // slli x16, x1, 31
00100893 0 11 00000001  // addi x17, x0, 1
41f85913 0 12 ffffffff  // srai x18, x16, 31
00115993 0 13 7ffffffe  // srli x19, x2, 1
40115a13 0 14 fffffffe  // srai x20, x2, 1
00011a93 0 15 fffffffd  // slli x21, x2, 0
01109b33 0 16 0000000a  // sll x22, x1, x17
40115bb3 0 17 ffffffff  // sra x23, x2, x1
02208133 1 00 00000000  // mul x2, x1, x2
008000ef 1 00 00000000  // jal x1, 8
00708013 0 00 00000000  // addi x0, x1, 7
06408093 0 01 00000069  // addi x1, x1, 100
003081b3 0 03 0000006b  // add x3, x1, x3
0011d193 0 03 00000035  // srli x3, x3, 1
fcb18213 0 04 00000000  // addi x4, x3, -53
00010cb3 0 19 fffffffd  // add x25, x2, x0
00000000 f 00 00000000  // end of list

// ==== all.f ====
+incdir+logic
logic/rv32i_pkg.sv
logic/rv32i_decode.sv
logic/rv32i_registers.sv
logic/rv32i_opfetch.sv
logic/rv32i_alu.sv
logic/rv32i_shifter.sv
logic/rv32i_writeback.sv
logic/rv32i_pipe.sv
tb/rv32i_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv32i_pipe_tb -Mdir "$BUILD_DIR" -o rv32i_pipe_sim -f all.f

"./$BUILD_DIR/rv32i_pipe_sim" | tee "$LOG_FILE"

if grep -q "sim failed" "$LOG_FILE"; then
  echo "simulation reported a failure, see $LOG_FILE"
  exit 1
fi
echo "simulation finished without failures"
